// File: include/lsb_consts.svh
`ifndef LSB_CONSTS_SVH
`define LSB_CONSTS_SVH

// queue slots; one slot stays free to tell full from empty
`define LSB_CAPACITY 8

// data and address width
`define LSB_WORD_WIDTH 32

// reorder buffer tag width
`define LSB_TAG_WIDTH 4

// operand tag meaning value present
`define LSB_NULL_TAG {`LSB_TAG_WIDTH{1'b0}}

`endif

// File: hdl/lsb_pkg.sv
`include "lsb_consts.svh"

package lsb_pkg;

    typedef logic [`LSB_WORD_WIDTH-1:0] word_t;
    typedef logic [`LSB_TAG_WIDTH-1:0] rob_tag_t;
    typedef logic [$clog2(`LSB_CAPACITY)-1:0] lsb_index_t;

    typedef enum logic [3:0] {
        LB, LBU, LH, LHU, LW, SB, SH, SW
    } ls_op_e;

    // access size in bytes
    typedef enum logic [2:0] {
        MEM_SIZE_1 = 3'd1,
        MEM_SIZE_2 = 3'd2,
        MEM_SIZE_4 = 3'd4
    } mem_size_e;

    // read word, whole or as low half / low byte lanes
    typedef union packed {
        word_t word;
        struct packed {
            logic [15:0] high_half;
            struct packed {
                logic [7:0] high_byte;
                logic [7:0] low_byte;
            } low_half;
        } lanes;
    } mem_word_u;

    function automatic logic op_is_store(ls_op_e op);
        return op inside {SB, SH, SW};
    endfunction

    function automatic mem_size_e op_size(ls_op_e op);
        case (op)
            LB, LBU, SB: return MEM_SIZE_1;
            LH, LHU, SH: return MEM_SIZE_2;
            default:     return MEM_SIZE_4;
        endcase
    endfunction

endpackage

// File: hdl/lsb_entry_queue.sv
`timescale 1ns/1ps
`include "lsb_consts.svh"

module lsb_entry_queue
    import lsb_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     dis_valid,
    input  ls_op_e   dis_op,
    input  rob_tag_t dis_tag,
    input  word_t    dis_vj,
    input  word_t    dis_vk,
    input  word_t    dis_imm,
    input  rob_tag_t dis_qj,
    input  rob_tag_t dis_qk,
    input  logic     alu_cdb_valid,
    input  word_t    alu_cdb_value,
    input  rob_tag_t alu_cdb_tag,
    input  logic     rob_cdb_valid,
    input  word_t    rob_cdb_value,
    input  rob_tag_t rob_cdb_tag,
    input  logic     lsb_cdb_valid,
    input  word_t    lsb_cdb_value,
    input  rob_tag_t lsb_cdb_tag,
    input  logic     pop,
    output logic     full,
    output logic     head_valid,
    output ls_op_e   head_op,
    output rob_tag_t head_tag,
    output rob_tag_t head_qj,
    output rob_tag_t head_qk,
    output word_t    head_address,
    output word_t    head_vk
);

    localparam int NUM_BUSES = 3;

    ls_op_e   op_q  [`LSB_CAPACITY];
    rob_tag_t tag_q [`LSB_CAPACITY];
    word_t    vj_q  [`LSB_CAPACITY];
    word_t    vk_q  [`LSB_CAPACITY];
    word_t    imm_q [`LSB_CAPACITY];
    rob_tag_t qj_q  [`LSB_CAPACITY];
    rob_tag_t qk_q  [`LSB_CAPACITY];

    lsb_index_t head;
    lsb_index_t tail;
    lsb_index_t count;
    logic [`LSB_CAPACITY-1:0] occupied;

    logic     bus_valid [NUM_BUSES];
    word_t    bus_value [NUM_BUSES];
    rob_tag_t bus_tag   [NUM_BUSES];

    function automatic logic bus_hit(rob_tag_t q, int b);
        return bus_valid[b] && q != `LSB_NULL_TAG && q == bus_tag[b];
    endfunction

    always_comb begin
        bus_valid[0] = alu_cdb_valid;
        bus_value[0] = alu_cdb_value;
        bus_tag[0]   = alu_cdb_tag;
        bus_valid[1] = rob_cdb_valid;
        bus_value[1] = rob_cdb_value;
        bus_tag[1]   = rob_cdb_tag;
        bus_valid[2] = lsb_cdb_valid;
        bus_value[2] = lsb_cdb_value;
        bus_tag[2]   = lsb_cdb_tag;
    end

    // slot is live when its distance from head is below the count
    assign count = tail - head;
    always_comb begin
        for (int s = 0; s < `LSB_CAPACITY; s++) begin
            occupied[s] = lsb_index_t'(lsb_index_t'(s) - head) < count;
        end
    end

    assign full       = lsb_index_t'(tail + 1'b1) == head;
    assign head_valid = count != '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (dis_valid) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // snoop all buses for waiting entries
        for (int s = 0; s < `LSB_CAPACITY; s++) begin
            if (occupied[s]) begin
                for (int b = 0; b < NUM_BUSES; b++) begin
                    if (bus_hit(qj_q[s], b)) begin
                        qj_q[s] <= `LSB_NULL_TAG;
                        vj_q[s] <= bus_value[b];
                    end
                    if (bus_hit(qk_q[s], b)) begin
                        qk_q[s] <= `LSB_NULL_TAG;
                        vk_q[s] <= bus_value[b];
                    end
                end
            end
        end
        if (dis_valid) begin
            op_q[tail]  <= dis_op;
            tag_q[tail] <= dis_tag;
            imm_q[tail] <= dis_imm;
            vj_q[tail]  <= dis_vj;
            vk_q[tail]  <= dis_vk;
            qj_q[tail]  <= dis_qj;
            qk_q[tail]  <= dis_qk;
            // result arriving in the dispatch cycle
            for (int b = 0; b < NUM_BUSES; b++) begin
                if (bus_hit(dis_qj, b)) begin
                    qj_q[tail] <= `LSB_NULL_TAG;
                    vj_q[tail] <= bus_value[b];
                end
                if (bus_hit(dis_qk, b)) begin
                    qk_q[tail] <= `LSB_NULL_TAG;
                    vk_q[tail] <= bus_value[b];
                end
            end
        end
    end

    assign head_op      = op_q[head];
    assign head_tag     = tag_q[head];
    assign head_qj      = qj_q[head];
    assign head_qk      = qk_q[head];
    assign head_address = vj_q[head] + imm_q[head];
    assign head_vk      = vk_q[head];

    // dispatcher must respect full
    a_no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (rst) !(dis_valid && full));

    // issue only from a non-empty queue
    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (rst) pop |-> head_valid);

endmodule

// File: hdl/lsb_commit_counter.sv
`timescale 1ns/1ps
`include "lsb_consts.svh"

module lsb_commit_counter (
    input  logic clk,
    input  logic rst,
    input  logic rob_commit,
    input  logic store_issue,
    output logic has_commit
);

    // one extra bit so overflow is visible
    logic [$clog2(`LSB_CAPACITY):0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (rob_commit && !store_issue) begin
            count <= count + 1'b1;
        end else if (store_issue && !rob_commit) begin
            count <= count - 1'b1;
        end
    end

    assign has_commit = count != '0;

    // stores leave in commit order, so an issue always has a commit behind it
    a_issue_needs_commit: assert property (
        @(posedge clk) disable iff (rst) store_issue |-> has_commit);

    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        (rob_commit && !store_issue) |-> count < `LSB_CAPACITY);

endmodule

// File: hdl/lsb_mem_fsm.sv
`timescale 1ns/1ps
`include "lsb_consts.svh"

module lsb_mem_fsm
    import lsb_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      head_valid,
    input  ls_op_e    head_op,
    input  rob_tag_t  head_tag,
    input  rob_tag_t  head_qj,
    input  rob_tag_t  head_qk,
    input  word_t     head_address,
    input  word_t     head_vk,
    input  logic      has_commit,
    input  logic      mem_ready,
    input  word_t     load_value,
    output logic      pop,
    output logic      store_issue,
    output logic      mem_request,
    output logic      mem_write,
    output word_t     mem_address,
    output mem_size_e mem_size,
    output word_t     mem_wdata,
    output ls_op_e    cur_op,
    output logic      lsb_cdb_valid,
    output word_t     lsb_cdb_value,
    output rob_tag_t  lsb_cdb_tag
);

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        STORE
    } state_e;

    state_e   state;
    rob_tag_t cur_tag;
    logic     head_is_store;
    logic     issue;

    assign head_is_store = op_is_store(head_op);

    // loads need the base only; stores also need data and a commit
    assign issue = state == IDLE && head_valid && head_qj == `LSB_NULL_TAG &&
                   (!head_is_store || (head_qk == `LSB_NULL_TAG && has_commit));

    assign pop         = issue;
    assign store_issue = issue && head_is_store;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            mem_request   <= 1'b0;
            lsb_cdb_valid <= 1'b0;
        end else begin
            mem_request   <= issue;
            lsb_cdb_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (issue) begin
                        state <= head_is_store ? STORE : LOAD;
                    end
                end
                LOAD: begin
                    if (mem_ready) begin
                        state         <= IDLE;
                        lsb_cdb_valid <= 1'b1;
                    end
                end
                STORE: begin
                    if (mem_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request fields held until the next issue
    always_ff @(posedge clk) begin
        if (issue) begin
            mem_write   <= head_is_store;
            mem_address <= head_address;
            mem_size    <= op_size(head_op);
            mem_wdata   <= head_vk;
            cur_op      <= head_op;
            cur_tag     <= head_tag;
        end
        if (state == LOAD && mem_ready) begin
            lsb_cdb_value <= load_value;
            lsb_cdb_tag   <= cur_tag;
        end
    end

    // memory answers only an outstanding request
    a_no_ready_in_idle: assert property (
        @(posedge clk) disable iff (rst) state == IDLE |-> !mem_ready);

endmodule

// File: hdl/load_align.sv
`timescale 1ns/1ps

module load_align
    import lsb_pkg::*;
(
    input  word_t  mem_rdata,
    input  ls_op_e cur_op,
    output word_t  load_value
);

    mem_word_u rdata;

    assign rdata = mem_rdata;

    always_comb begin
        case (cur_op)
            LB: load_value = {{24{rdata.lanes.low_half.low_byte[7]}},
                              rdata.lanes.low_half.low_byte};
            LBU: load_value = {24'b0, rdata.lanes.low_half.low_byte};
            LH: load_value = {{16{rdata.lanes.low_half.high_byte[7]}},
                              rdata.lanes.low_half};
            LHU: load_value = {16'b0, rdata.lanes.low_half};
            // full word, also the store opcodes which never broadcast
            default: load_value = rdata.word;
        endcase
    end

endmodule

// File: hdl/load_store_buffer.sv
`timescale 1ns/1ps

module load_store_buffer
    import lsb_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      dis_valid,
    input  ls_op_e    dis_op,
    input  rob_tag_t  dis_tag,
    input  word_t     dis_vj,
    input  word_t     dis_vk,
    input  word_t     dis_imm,
    input  rob_tag_t  dis_qj,
    input  rob_tag_t  dis_qk,
    input  logic      alu_cdb_valid,
    input  word_t     alu_cdb_value,
    input  rob_tag_t  alu_cdb_tag,
    input  logic      rob_cdb_valid,
    input  word_t     rob_cdb_value,
    input  rob_tag_t  rob_cdb_tag,
    input  logic      rob_commit,
    input  logic      mem_ready,
    input  word_t     mem_rdata,
    output logic      mem_request,
    output logic      mem_write,
    output word_t     mem_address,
    output mem_size_e mem_size,
    output word_t     mem_wdata,
    output logic      lsb_cdb_valid,
    output word_t     lsb_cdb_value,
    output rob_tag_t  lsb_cdb_tag,
    output logic      full
);

    logic     pop;
    logic     store_issue;
    logic     has_commit;
    logic     head_valid;
    ls_op_e   head_op;
    rob_tag_t head_tag;
    rob_tag_t head_qj;
    rob_tag_t head_qk;
    word_t    head_address;
    word_t    head_vk;
    ls_op_e   cur_op;
    word_t    load_value;

    // load results also feed back into the queue
    lsb_entry_queue i_queue (
        .clk(clk), .rst(rst),
        .dis_valid(dis_valid), .dis_op(dis_op), .dis_tag(dis_tag),
        .dis_vj(dis_vj), .dis_vk(dis_vk), .dis_imm(dis_imm),
        .dis_qj(dis_qj), .dis_qk(dis_qk),
        .alu_cdb_valid(alu_cdb_valid), .alu_cdb_value(alu_cdb_value),
        .alu_cdb_tag(alu_cdb_tag),
        .rob_cdb_valid(rob_cdb_valid), .rob_cdb_value(rob_cdb_value),
        .rob_cdb_tag(rob_cdb_tag),
        .lsb_cdb_valid(lsb_cdb_valid), .lsb_cdb_value(lsb_cdb_value),
        .lsb_cdb_tag(lsb_cdb_tag),
        .pop(pop), .full(full), .head_valid(head_valid),
        .head_op(head_op), .head_tag(head_tag),
        .head_qj(head_qj), .head_qk(head_qk),
        .head_address(head_address), .head_vk(head_vk)
    );

    lsb_commit_counter i_commit_counter (
        .clk(clk), .rst(rst),
        .rob_commit(rob_commit), .store_issue(store_issue),
        .has_commit(has_commit)
    );

    lsb_mem_fsm i_mem_fsm (
        .clk(clk), .rst(rst),
        .head_valid(head_valid), .head_op(head_op), .head_tag(head_tag),
        .head_qj(head_qj), .head_qk(head_qk),
        .head_address(head_address), .head_vk(head_vk),
        .has_commit(has_commit), .mem_ready(mem_ready), .load_value(load_value),
        .pop(pop), .store_issue(store_issue),
        .mem_request(mem_request), .mem_write(mem_write),
        .mem_address(mem_address), .mem_size(mem_size), .mem_wdata(mem_wdata),
        .cur_op(cur_op),
        .lsb_cdb_valid(lsb_cdb_valid), .lsb_cdb_value(lsb_cdb_value),
        .lsb_cdb_tag(lsb_cdb_tag)
    );

    load_align i_load_align (
        .mem_rdata(mem_rdata),
        .cur_op(cur_op),
        .load_value(load_value)
    );

endmodule

// File: testbench/tb_load_store_buffer.sv
`timescale 1ns/1ps

module tb_load_store_buffer
    import lsb_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int NUM_OPS = 40;
    localparam int BUS_ALU = 0;
    localparam int BUS_ROB = 1;

    typedef struct packed {
        ls_op_e   op;
        rob_tag_t tag;
        word_t    vj;
        word_t    vk;
        word_t    imm;
        rob_tag_t qj;
        rob_tag_t qk;
    } access_t;

    logic      clk;
    logic      rst;
    logic      dis_valid;
    ls_op_e    dis_op;
    rob_tag_t  dis_tag;
    word_t     dis_vj;
    word_t     dis_vk;
    word_t     dis_imm;
    rob_tag_t  dis_qj;
    rob_tag_t  dis_qk;
    logic      alu_cdb_valid;
    word_t     alu_cdb_value;
    rob_tag_t  alu_cdb_tag;
    logic      rob_cdb_valid;
    word_t     rob_cdb_value;
    rob_tag_t  rob_cdb_tag;
    logic      rob_commit;
    logic      mem_ready;
    word_t     mem_rdata;
    logic      mem_request;
    logic      mem_write;
    word_t     mem_address;
    mem_size_e mem_size;
    word_t     mem_wdata;
    logic      lsb_cdb_valid;
    word_t     lsb_cdb_value;
    rob_tag_t  lsb_cdb_tag;
    logic      full;

    logic [7:0]  mem_bytes [256];
    logic [31:0] seed = 32'h2c97_7119;
    access_t     exp_q [$];
    rob_tag_t    bcast_tag_q [$];
    word_t       bcast_value_q [$];
    word_t       tag_value [16];
    logic        tag_resolved [16];
    rob_tag_t    next_tag;
    int          commits_sent;
    int          stores_issued;
    logic        mem_busy;
    int          value_errors;
    int          protocol_errors;

    load_store_buffer i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic word_t read_word(word_t addr);
        return {mem_bytes[8'(addr + 3)], mem_bytes[8'(addr + 2)],
                mem_bytes[8'(addr + 1)], mem_bytes[addr[7:0]]};
    endfunction

    // expected load result from the model bytes
    function automatic word_t load_ref(ls_op_e op, word_t addr);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = mem_bytes[addr[7:0]];
        b1 = mem_bytes[8'(addr + 1)];
        case (op)
            LB:      return {{24{b0[7]}}, b0};
            LBU:     return {24'h0, b0};
            LH:      return {{16{b1[7]}}, b1, b0};
            LHU:     return {16'h0, b1, b0};
            default: return read_word(addr);
        endcase
    endfunction

    function automatic int access_bytes(ls_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            default:     return 4;
        endcase
    endfunction

    // tags cycle through 1..15 as 0 is the null tag
    function automatic rob_tag_t new_tag();
        next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        tag_resolved[next_tag] = 1'b0;
        return next_tag;
    endfunction

    task automatic expect_word(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic protocol_error(string msg);
        $display("at %0t ns: %s", $time, msg);
        protocol_errors++;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #5;
        dis_valid = 1'b0;
        alu_cdb_valid = 1'b0;
        rob_cdb_valid = 1'b0;
        rob_commit = 1'b0;
    endtask

    task automatic put_entry(ls_op_e op, rob_tag_t tag, word_t vj, word_t vk, word_t imm,
                             rob_tag_t qj, rob_tag_t qk);
        access_t e;
        while (full) begin
            next_cycle();
        end
        dis_valid = 1'b1;
        dis_op = op;
        dis_tag = tag;
        dis_vj = vj;
        dis_vk = vk;
        dis_imm = imm;
        dis_qj = qj;
        dis_qk = qk;
        e = '{op, tag, vj, vk, imm, qj, qk};
        exp_q.push_back(e);
    endtask

    task automatic put_result(int bus, rob_tag_t tag, word_t value);
        tag_value[tag] = value;
        tag_resolved[tag] = 1'b1;
        if (bus == BUS_ALU) begin
            alu_cdb_valid = 1'b1;
            alu_cdb_tag = tag;
            alu_cdb_value = value;
        end else begin
            rob_cdb_valid = 1'b1;
            rob_cdb_tag = tag;
            rob_cdb_value = value;
        end
    endtask

    task automatic commit_store();
        rob_commit = 1'b1;
        commits_sent++;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || bcast_tag_q.size() != 0 || mem_busy) begin
            next_cycle();
        end
        repeat (2) next_cycle();
    endtask

    task automatic check_request();
        access_t e;
        word_t   addr;
        word_t   value;
        logic    store;
        if (exp_q.size() == 0) begin
            protocol_error("memory request with no access pending");
            return;
        end
        e = exp_q.pop_front();
        store = e.op inside {SB, SH, SW};
        if (e.qj != 4'd0 && !tag_resolved[e.qj]) begin
            protocol_error("access issued before its base operand arrived");
        end
        addr = ((e.qj == 4'd0) ? e.vj : tag_value[e.qj]) + e.imm;
        expect_word("mem_write", word_t'(store), word_t'(mem_write));
        expect_word("mem_address", addr, mem_address);
        expect_word("mem_size", word_t'(access_bytes(e.op)), word_t'(mem_size));
        if (store) begin
            if (e.qk != 4'd0 && !tag_resolved[e.qk]) begin
                protocol_error("store issued before its data arrived");
            end
            if (stores_issued >= commits_sent) begin
                protocol_error("store requested before its commit");
            end
            stores_issued++;
            value = (e.qk == 4'd0) ? e.vk : tag_value[e.qk];
            expect_word("mem_wdata", value, mem_wdata);
        end else begin
            value = load_ref(e.op, addr);
            tag_value[e.tag] = value;
            bcast_tag_q.push_back(e.tag);
            bcast_value_q.push_back(value);
        end
    endtask

    task automatic check_broadcast();
        rob_tag_t tag;
        word_t    value;
        if (bcast_tag_q.size() == 0) begin
            protocol_error("load broadcast with no load outstanding");
            return;
        end
        tag = bcast_tag_q.pop_front();
        value = bcast_value_q.pop_front();
        expect_word("lsb_cdb_tag", word_t'(tag), word_t'(lsb_cdb_tag));
        expect_word("lsb_cdb_value", value, lsb_cdb_value);
        tag_resolved[tag] = 1'b1;
    endtask

    // compares every request and broadcast in program order
    initial begin : compare
        forever begin
            @(posedge clk);
            if (!rst && mem_request) begin
                check_request();
            end
            if (!rst && lsb_cdb_valid) begin
                check_broadcast();
            end
        end
    end

    initial begin : memory_model
        int    latency;
        word_t addr;
        word_t data;
        logic  write;
        int    size;
        forever begin
            @(posedge clk);
            if (!rst && mem_request) begin
                mem_busy = 1'b1;
                latency = int'(next_rand() >> 30) + 1;
                addr = mem_address;
                data = mem_wdata;
                write = mem_write;
                size = int'(mem_size);
                repeat (latency - 1) @(posedge clk);
                #5;
                if (write) begin
                    for (int k = 0; k < size; k++) begin
                        mem_bytes[8'(addr + k)] = data[8*k +: 8];
                    end
                end else begin
                    mem_rdata = read_word(addr);
                end
                mem_ready = 1'b1;
                @(posedge clk);
                #5;
                mem_ready = 1'b0;
                mem_busy = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(NUM_OPS * 20 * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", NUM_OPS * 20);
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        rob_tag_t t;
        rob_tag_t p;
        word_t    a;
        ls_op_e   load_ops [5];
        ls_op_e   store_ops [3];
        load_ops = '{LB, LBU, LH, LHU, LW};
        store_ops = '{SW, SH, SB};
        clk = 1'b0;
        rst = 1'b1;
        dis_valid = 1'b0;
        dis_op = LB;
        dis_tag = '0;
        dis_vj = '0;
        dis_vk = '0;
        dis_imm = '0;
        dis_qj = '0;
        dis_qk = '0;
        alu_cdb_valid = 1'b0;
        alu_cdb_value = '0;
        alu_cdb_tag = '0;
        rob_cdb_valid = 1'b0;
        rob_cdb_value = '0;
        rob_cdb_tag = '0;
        rob_commit = 1'b0;
        mem_ready = 1'b0;
        mem_rdata = '0;
        next_tag = '0;
        commits_sent = 0;
        stores_issued = 0;
        mem_busy = 1'b0;
        value_errors = 0;
        protocol_errors = 0;
        for (int i = 0; i < 16; i++) begin
            tag_value[i] = '0;
            tag_resolved[i] = 1'b0;
        end
        for (int i = 0; i < 256; i++) begin
            mem_bytes[i] = 8'(next_rand() >> 24) ^ 8'(i);
        end
        repeat (3) @(posedge clk);
        #5;
        rst = 1'b0;

        expect_word("full", 0, word_t'(full));
        expect_word("mem_request", 0, word_t'(mem_request));
        expect_word("lsb_cdb_valid", 0, word_t'(lsb_cdb_valid));
        repeat (8) next_cycle();

        // every load width back to back
        for (int i = 0; i < 20; i++) begin
            put_entry(load_ops[i % 5], new_tag(), next_rand() & 32'h7f, next_rand(),
                      next_rand() & 32'h3f, '0, '0);
            next_cycle();
        end
        wait_drained();

        // stores held until commit and then read back
        for (int i = 0; i < 3; i++) begin
            a = next_rand() & 32'hf0;
            put_entry(store_ops[i], new_tag(), a, next_rand(), 32'h8, '0, '0);
            repeat (6) next_cycle();
            commit_store();
            next_cycle();
            put_entry(LW, new_tag(), a + 32'h8, '0, '0, '0, '0);
            next_cycle();
            wait_drained();
        end

        // base waits for an ALU result
        t = new_tag();
        p = new_tag();
        put_entry(LW, t, next_rand(), '0, 32'h10, p, '0);
        repeat (3) next_cycle();
        put_result(BUS_ALU, p, next_rand() & 32'h7f);
        next_cycle();
        // data waits for a reorder buffer result
        p = new_tag();
        put_entry(SH, new_tag(), next_rand() & 32'h7f, next_rand(), 32'h4, '0, p);
        commit_store();
        repeat (10) next_cycle();
        put_result(BUS_ROB, p, next_rand());
        next_cycle();
        // operands that arrive in the dispatch cycle
        p = new_tag();
        put_entry(LH, new_tag(), next_rand(), '0, 32'h2, p, '0);
        put_result(BUS_ALU, p, next_rand() & 32'h7f);
        next_cycle();
        p = new_tag();
        put_entry(SW, new_tag(), next_rand(), next_rand(), '0, p, '0);
        put_result(BUS_ROB, p, next_rand() & 32'hfc);
        commit_store();
        next_cycle();
        wait_drained();

        // store data forwarded from an earlier load
        t = new_tag();
        a = next_rand() & 32'hfc;
        put_entry(LW, t, next_rand() & 32'h7f, '0, '0, '0, '0);
        next_cycle();
        put_entry(SW, new_tag(), a, next_rand(), '0, '0, t);
        commit_store();
        next_cycle();
        put_entry(LW, new_tag(), a, '0, '0, '0, '0);
        next_cycle();
        wait_drained();

        // uncommitted store at the head blocks the queue until full
        put_entry(SW, new_tag(), next_rand() & 32'hfc, next_rand(), '0, '0, '0);
        next_cycle();
        for (int i = 0; i < 6; i++) begin
            put_entry(load_ops[i % 5], new_tag(), next_rand() & 32'h7f, '0,
                      next_rand() & 32'h3f, '0, '0);
            next_cycle();
            expect_word("full", word_t'(i == 5), word_t'(full));
        end
        commit_store();
        next_cycle();
        wait_drained();

        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+include
hdl/lsb_pkg.sv
hdl/lsb_entry_queue.sv
hdl/lsb_commit_counter.sv
hdl/lsb_mem_fsm.sv
hdl/load_align.sv
hdl/load_store_buffer.sv
testbench/tb_load_store_buffer.sv

// File: Makefile
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
TOP        := tb_load_store_buffer
FILELIST   := list.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Simulation passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
